//--- verilog/decode_pkg.sv
// Decode stage types: data word, register index, opcodes and the control and ID/EX bundles
package decode_pkg;

    typedef logic [15:0] word_t;     // Data word, 16 bits fixed by the ISA
    typedef logic [3:0]  reg_idx_t;  // Register file index
    typedef logic [2:0]  br_cond_t;  // Branch condition, instr[10:8]
    typedef logic [11:0] target_t;   // Call target, instr[11:0]
    typedef logic [2:0]  alu_op_t;   // ALU operation code
    typedef logic [1:0]  base_sel_t; // Source of the port 1 read index

    // Opcode field, instr[15:12]
    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_ADDI = 4'd4,  // 4-bit imm in [3:0]
        OP_LW   = 4'd8,  // Reg in [11:8], 8-bit imm in [7:0]
        OP_SW   = 4'd9,
        OP_BR   = 4'd12, // Condition in [10:8]
        OP_CALL = 4'd13, // Target in [11:0]
        OP_RET  = 4'd14,
        OP_NOP  = 4'd15
    } opcode_t;

    localparam alu_op_t ALU_ADD = 3'd0;
    localparam alu_op_t ALU_SUB = 3'd1;
    localparam alu_op_t ALU_AND = 3'd2;
    localparam alu_op_t ALU_OR  = 3'd3;

    localparam base_sel_t BASE_RS = 2'd0; // rs field, instr[7:4]
    localparam base_sel_t BASE_DS = 2'd1; // Data segment register
    localparam base_sel_t BASE_SP = 2'd2; // Stack pointer

    localparam logic IMM_ARITH = 1'b0;    // Extend instr[3:0]
    localparam logic IMM_LS    = 1'b1;    // Extend instr[7:0]

    localparam reg_idx_t SP_IDX = 4'd15;
    localparam reg_idx_t DS_IDX = 4'd14;

    // Control bundle carried down the pipe
    typedef struct packed {
        logic    mem_to_reg; // LW result goes to the register file
        logic    reg_to_mem; // SW
        logic    alu_src;    // Immediate on ALU operand B
        alu_op_t alu_op;
        logic    branch;
        logic    call;
        logic    ret;
        logic    reg_write;
    } ctrl_t;

    // Everything execute needs from decode
    typedef struct packed {
        ctrl_t    ctrl;
        word_t    read_data_1;
        word_t    read_data_2;
        word_t    sign_ext;
        reg_idx_t dest;        // instr[11:8]
        br_cond_t branch_cond; // Pass-through
        target_t  call_target; // Pass-through
        word_t    pc;          // Pass-through
    } id_ex_t;

endpackage

//--- verilog/reg_file.sv
// Register file, two combinational read ports with write-first bypass, r15 resets to all ones
`timescale 1ns/1ps

module reg_file
    import decode_pkg::*;
#(
    parameter int REG_COUNT = 16
) (
    input  logic     clk,
    input  logic     rst,
    input  reg_idx_t rd_idx_1,   // Port 1 index, rs or base register
    input  reg_idx_t rd_idx_2,   // Port 2 index, rt
    input  logic     wb_en,      // Writeback strobe from later stages
    input  reg_idx_t wb_idx,
    input  word_t    wb_data,
    output word_t    read_data_1,
    output word_t    read_data_2
);

    word_t regs [REG_COUNT];     // Register array

    logic  bypass_1;             // Writeback hits port 1 this cycle
    logic  bypass_2;

    // Write commits on the edge
    // Reset loads zero except the stack pointer
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                if (i == int'(SP_IDX))
                    regs[i] <= '1;   // Stack starts at top of memory
                else
                    regs[i] <= '0;
            end
        end else if (wb_en) begin
            regs[wb_idx] <= wb_data;
        end
    end

    assign bypass_1 = wb_en && (wb_idx == rd_idx_1);
    assign bypass_2 = wb_en && (wb_idx == rd_idx_2);

    // Write-first, so decode sees the value committed at this edge
    always_comb begin
        if (bypass_1)
            read_data_1 = wb_data;
        else
            read_data_1 = regs[rd_idx_1];

        if (bypass_2)
            read_data_2 = wb_data;
        else
            read_data_2 = regs[rd_idx_2];
    end

endmodule

//--- verilog/control_decoder.sv
// Opcode decoder producing the control bundle, register-use flags and operand selects
`timescale 1ns/1ps

module control_decoder
    import decode_pkg::*;
(
    input  opcode_t   opcode,
    output ctrl_t     ctrl,
    output logic      uses_rs,     // Port 1 index is a real source
    output logic      uses_rt,     // Port 2 index is a real source
    output logic      rt_from_ls,  // Port 2 from instr[11:8] (SW data)
    output base_sel_t base_sel,
    output logic      imm_sel
);

    always_comb begin
        // Defaults give NOP, also for undefined codes
        ctrl       = '0;
        uses_rs    = 1'b0;
        uses_rt    = 1'b0;
        rt_from_ls = 1'b0;
        base_sel   = BASE_RS;
        imm_sel    = IMM_ARITH;

        case (opcode)
            OP_ADD: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = ALU_ADD;
                uses_rs        = 1'b1;
                uses_rt        = 1'b1;
            end
            OP_SUB: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = ALU_SUB;
                uses_rs        = 1'b1;
                uses_rt        = 1'b1;
            end
            OP_AND: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = ALU_AND;
                uses_rs        = 1'b1;
                uses_rt        = 1'b1;
            end
            OP_OR: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = ALU_OR;
                uses_rs        = 1'b1;
                uses_rt        = 1'b1;
            end
            OP_ADDI: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = ALU_ADD;
                ctrl.alu_src   = 1'b1;   // 4-bit imm on operand B
                uses_rs        = 1'b1;
            end
            OP_LW: begin
                ctrl.mem_to_reg = 1'b1;
                ctrl.reg_write  = 1'b1;
                ctrl.alu_src    = 1'b1;  // DS + offset
                ctrl.alu_op     = ALU_ADD;
                base_sel        = BASE_DS;
                uses_rs         = 1'b1;  // Base reg is read on port 1
                imm_sel         = IMM_LS;
            end
            OP_SW: begin
                ctrl.reg_to_mem = 1'b1;
                ctrl.alu_src    = 1'b1;
                ctrl.alu_op     = ALU_ADD;
                base_sel        = BASE_DS;
                uses_rs         = 1'b1;
                uses_rt         = 1'b1;
                rt_from_ls      = 1'b1;  // Store data from [11:8]
                imm_sel         = IMM_LS;
            end
            OP_BR: ctrl.branch = 1'b1;   // Condition passes through
            OP_CALL: begin
                ctrl.call = 1'b1;
                base_sel  = BASE_SP;     // Return address pushed via SP
                uses_rs   = 1'b1;
            end
            OP_RET: begin
                ctrl.ret = 1'b1;
                base_sel = BASE_SP;
                uses_rs  = 1'b1;
            end
            default: ;                   // NOP and unused codes
        endcase
    end

endmodule

//--- verilog/operand_select.sv
// Operand selector picking register read indices, destination and the sign-extended immediate
`timescale 1ns/1ps

module operand_select
    import decode_pkg::*;
(
    input  word_t     instr,
    input  base_sel_t base_sel,    // rs, DS or SP on port 1
    input  logic      rt_from_ls,
    input  logic      imm_sel,
    output reg_idx_t  rd_idx_1,
    output reg_idx_t  rd_idx_2,
    output word_t     sign_ext,
    output reg_idx_t  dest
);

    reg_idx_t    rs_field;        // instr[7:4]
    reg_idx_t    rt_field;        // instr[3:0]
    reg_idx_t    ls_reg_field;    // instr[11:8]
    logic [3:0]  arith_imm;
    logic [7:0]  ls_imm;

    // Instruction fields
    assign rs_field     = instr[7:4];
    assign rt_field     = instr[3:0];
    assign ls_reg_field = instr[11:8];
    assign arith_imm    = instr[3:0];
    assign ls_imm       = instr[7:0];

    // Port 1 source
    always_comb begin
        case (base_sel)
            BASE_DS: rd_idx_1 = DS_IDX;
            BASE_SP: rd_idx_1 = SP_IDX;
            default: rd_idx_1 = rs_field;
        endcase
    end

    // Port 2 takes the store data register for SW
    always_comb begin
        if (rt_from_ls)
            rd_idx_2 = ls_reg_field;
        else
            rd_idx_2 = rt_field;
    end

    // Sign extension of the selected immediate
    always_comb begin
        if (imm_sel == IMM_LS)
            sign_ext = {{8{ls_imm[7]}}, ls_imm};
        else
            sign_ext = {{12{arith_imm[3]}}, arith_imm};
    end

    // Destination always sits in [11:8]
    assign dest = ls_reg_field;

endmodule

//--- verilog/hazard_detect.sv
// Hazard detector raising stall when a used source matches a valid in-flight destination
`timescale 1ns/1ps

module hazard_detect
    import decode_pkg::*;
(
    input  logic     instr_valid,      // Stall only means something on a strobe
    input  reg_idx_t rd_idx_1,
    input  reg_idx_t rd_idx_2,
    input  logic     uses_rs,
    input  logic     uses_rt,
    input  reg_idx_t id_ex_rd,
    input  logic     id_ex_rd_valid,
    input  reg_idx_t ex_mem_rd,
    input  logic     ex_mem_rd_valid,
    input  reg_idx_t mem_wb_rd,
    input  logic     mem_wb_rd_valid,
    output logic     stall
);

    logic rs_hit;   // Port 1 source still being produced
    logic rt_hit;

    assign rs_hit = uses_rs &&
                    ((id_ex_rd_valid  && (rd_idx_1 == id_ex_rd))  ||
                     (ex_mem_rd_valid && (rd_idx_1 == ex_mem_rd)) ||
                     (mem_wb_rd_valid && (rd_idx_1 == mem_wb_rd)));

    assign rt_hit = uses_rt &&
                    ((id_ex_rd_valid  && (rd_idx_2 == id_ex_rd))  ||
                     (ex_mem_rd_valid && (rd_idx_2 == ex_mem_rd)) ||
                     (mem_wb_rd_valid && (rd_idx_2 == mem_wb_rd)));

    // No forwarding, so any match holds the instruction in decode
    assign stall = instr_valid && (rs_hit || rt_hit);

endmodule

//--- verilog/id_ex_reg.sv
// ID/EX pipeline register capturing the decoded bundle, or a bubble on stall or idle
`timescale 1ns/1ps

module id_ex_reg
    import decode_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     instr_valid,
    input  logic     stall,
    input  ctrl_t    ctrl,
    input  word_t    read_data_1,
    input  word_t    read_data_2,
    input  word_t    sign_ext,
    input  reg_idx_t dest,
    input  word_t    instr,      // Source of the pass-through fields
    input  word_t    pc,
    output logic     ex_valid,
    output id_ex_t   ex_bundle
);

    logic     take;              // Non-stalled strobe
    ctrl_t    ctrl_q;
    word_t    rd1_q;
    word_t    rd2_q;
    word_t    sext_q;
    reg_idx_t dest_q;
    br_cond_t cond_q;
    target_t  target_q;
    word_t    pc_q;

    assign take = instr_valid && !stall;

    // Control state, bubble is a zero ctrl
    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid <= 1'b0;
            ctrl_q   <= '0;
        end else begin
            ex_valid <= take;
            ctrl_q   <= take ? ctrl : '0;
        end
    end

    // Payload only moves with a valid instruction
    always_ff @(posedge clk) begin
        if (take) begin
            rd1_q    <= read_data_1;
            rd2_q    <= read_data_2;
            sext_q   <= sign_ext;
            dest_q   <= dest;
            cond_q   <= instr[10:8];
            target_q <= instr[11:0];
            pc_q     <= pc;
        end
    end

    always_comb begin
        ex_bundle.ctrl        = ctrl_q;
        ex_bundle.read_data_1 = rd1_q;
        ex_bundle.read_data_2 = rd2_q;
        ex_bundle.sign_ext    = sext_q;
        ex_bundle.dest        = dest_q;
        ex_bundle.branch_cond = cond_q;
        ex_bundle.call_target = target_q;
        ex_bundle.pc          = pc_q;
    end

endmodule

//--- verilog/decode_top.sv
// Decode stage top, register file, control decode, operand select, hazard check and ID/EX register
`timescale 1ns/1ps

module decode_top
    import decode_pkg::*;
#(
    parameter int REG_COUNT = 16
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     instr_valid,     // One-cycle strobe from fetch
    input  word_t    instr,
    input  word_t    pc,
    input  logic     wb_en,           // Writeback port
    input  reg_idx_t wb_idx,
    input  word_t    wb_data,
    input  reg_idx_t id_ex_rd,        // In-flight destinations
    input  logic     id_ex_rd_valid,
    input  reg_idx_t ex_mem_rd,
    input  logic     ex_mem_rd_valid,
    input  reg_idx_t mem_wb_rd,
    input  logic     mem_wb_rd_valid,
    output logic     stall,           // Fetch repeats the instruction
    output logic     ex_valid,
    output id_ex_t   ex_bundle
);

    opcode_t   opcode;
    ctrl_t     ctrl;
    logic      uses_rs;
    logic      uses_rt;
    logic      rt_from_ls;
    base_sel_t base_sel;
    logic      imm_sel;
    reg_idx_t  rd_idx_1;
    reg_idx_t  rd_idx_2;
    reg_idx_t  dest;
    word_t     sign_ext;
    word_t     read_data_1;
    word_t     read_data_2;

    assign opcode = opcode_t'(instr[15:12]); // Unlisted codes fall to default

    control_decoder control_decoder_inst (
        .opcode     (opcode),
        .ctrl       (ctrl),
        .uses_rs    (uses_rs),
        .uses_rt    (uses_rt),
        .rt_from_ls (rt_from_ls),
        .base_sel   (base_sel),
        .imm_sel    (imm_sel)
    );

    operand_select operand_select_inst (
        .instr      (instr),
        .base_sel   (base_sel),
        .rt_from_ls (rt_from_ls),
        .imm_sel    (imm_sel),
        .rd_idx_1   (rd_idx_1),
        .rd_idx_2   (rd_idx_2),
        .sign_ext   (sign_ext),
        .dest       (dest)
    );

    // Register file sits beside the operand selector it is steered by
    reg_file #(
        .REG_COUNT (REG_COUNT)
    ) reg_file_inst (
        .clk         (clk),
        .rst         (rst),
        .rd_idx_1    (rd_idx_1),
        .rd_idx_2    (rd_idx_2),
        .wb_en       (wb_en),
        .wb_idx      (wb_idx),
        .wb_data     (wb_data),
        .read_data_1 (read_data_1),
        .read_data_2 (read_data_2)
    );

    hazard_detect hazard_detect_inst (
        .instr_valid     (instr_valid),
        .rd_idx_1        (rd_idx_1),
        .rd_idx_2        (rd_idx_2),
        .uses_rs         (uses_rs),
        .uses_rt         (uses_rt),
        .id_ex_rd        (id_ex_rd),
        .id_ex_rd_valid  (id_ex_rd_valid),
        .ex_mem_rd       (ex_mem_rd),
        .ex_mem_rd_valid (ex_mem_rd_valid),
        .mem_wb_rd       (mem_wb_rd),
        .mem_wb_rd_valid (mem_wb_rd_valid),
        .stall           (stall)
    );

    id_ex_reg id_ex_reg_inst (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .stall       (stall),
        .ctrl        (ctrl),
        .read_data_1 (read_data_1),
        .read_data_2 (read_data_2),
        .sign_ext    (sign_ext),
        .dest        (dest),
        .instr       (instr),
        .pc          (pc),
        .ex_valid    (ex_valid),
        .ex_bundle   (ex_bundle)
    );

endmodule

//--- test/decode_assert.sv
// Decode stage assertions for reset state, stall bubbles and zero ctrl on idle cycles
`timescale 1ns/1ps

module decode_assert
    import decode_pkg::*;
(
    input logic   clk,
    input logic   rst,
    input logic   instr_valid,
    input logic   stall,
    input logic   ex_valid,
    input id_ex_t ex_bundle
);

    int assert_errors = 0;   // Read by the testbench summary

    // Reset leaves the ID/EX register empty
    reset_clears: assert property (@(posedge clk) rst |=> !ex_valid)
        else begin
            assert_errors++;
            $error("ex_valid set after a reset cycle");
        end

    // Stalled strobe becomes a bubble
    stall_bubble: assert property (@(posedge clk) disable iff (rst)
                                   (instr_valid && stall) |=> !ex_valid)
        else begin
            assert_errors++;
            $error("ex_valid set after a stalled instruction");
        end

    idle_ctrl: assert property (@(posedge clk) disable iff (rst)
                                !ex_valid |-> (ex_bundle.ctrl == '0))
        else begin
            assert_errors++;
            $error("ctrl not zero while ex_valid is low");
        end

endmodule

bind decode_top decode_assert decode_assert_inst (
    .clk         (clk),
    .rst         (rst),
    .instr_valid (instr_valid),
    .stall       (stall),
    .ex_valid    (ex_valid),
    .ex_bundle   (ex_bundle)
);

//--- test/decode_tb.sv
// Directed testbench for the decode stage and ID/EX register
`timescale 1ns/1ps

module decode_tb
    import decode_pkg::*;
();

    logic     clk;
    logic     rst;
    logic     instr_valid;
    word_t    instr;
    word_t    pc;
    logic     wb_en;
    reg_idx_t wb_idx;
    word_t    wb_data;
    reg_idx_t id_ex_rd;
    logic     id_ex_rd_valid;
    reg_idx_t ex_mem_rd;
    logic     ex_mem_rd_valid;
    reg_idx_t mem_wb_rd;
    logic     mem_wb_rd_valid;
    logic     stall;
    logic     ex_valid;
    id_ex_t   ex_bundle;

    int          errors;
    int          checks;
    logic [15:0] lfsr;          // Galois LFSR state
    word_t       model [16];    // Expected register contents

    decode_top #(.REG_COUNT(16)) decode_top_inst (.*);

    always #5 clk = ~clk;       // 10 ns period

    // Right shift, taps 16,14,13,11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[14:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp)
        else begin
            errors++;
            $display("error %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic write_reg(input reg_idx_t idx, input word_t d);
        @(posedge clk);
        wb_en   <= 1'b1;
        wb_idx  <= idx;
        wb_data <= d;
        @(posedge clk);
        wb_en <= 1'b0;
        model[idx] = d;
    endtask

    task automatic set_inflight(input reg_idx_t a, input logic av, input reg_idx_t b,
                                input logic bv, input reg_idx_t c, input logic cv);
        @(posedge clk);
        id_ex_rd        <= a;
        id_ex_rd_valid  <= av;
        ex_mem_rd       <= b;
        ex_mem_rd_valid <= bv;
        mem_wb_rd       <= c;
        mem_wb_rd_valid <= cv;
    endtask

    // One-cycle strobe, optional writeback in the same cycle, returns at a negedge
    task automatic issue(input word_t ins, input word_t pcv, input logic exp_stall,
                         input logic wb_on, input reg_idx_t wb_i, input word_t wb_d);
        int n;
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= ins;
        pc          <= pcv;
        wb_en       <= wb_on;
        wb_idx      <= wb_i;
        wb_data     <= wb_d;
        @(negedge clk);
        check_eq("stall", 32'(stall), 32'(exp_stall));   // Combinational in strobe cycle
        @(posedge clk);
        instr_valid <= 1'b0;
        wb_en       <= 1'b0;
        @(negedge clk);
        if (exp_stall) begin
            check_eq("ex_valid after stall", 32'(ex_valid), 0);
            check_eq("ctrl after stall", 32'(ex_bundle.ctrl), 0);
        end else begin
            n = 0;
            while (!ex_valid && n < 8) begin
                @(negedge clk);
                n++;
            end
            if (!ex_valid) begin
                errors++;
                $display("timeout: ex_valid never rose for instruction %h", ins);
            end else begin
                check_eq("ex_valid latency", 32'(n), 0);   // One cycle after the strobe
            end
        end
    endtask

    // r15 resets to all ones, seen through CALL and RET
    task automatic stack_test();
        ctrl_t exp_c;
        check_eq("ex_valid after reset", 32'(ex_valid), 0);
        check_eq("ctrl after reset", 32'(ex_bundle.ctrl), 0);
        issue({4'd13, 12'hABC}, 16'h0010, 1'b0, 1'b0, '0, '0);
        exp_c = '0;
        exp_c.call = 1'b1;
        check_eq("CALL ctrl", 32'(ex_bundle.ctrl), 32'(exp_c));
        check_eq("CALL sp", 32'(ex_bundle.read_data_1), 32'hFFFF);
        check_eq("CALL target", 32'(ex_bundle.call_target), 32'hABC);
        issue({4'd14, 12'h000}, 16'h0011, 1'b0, 1'b0, '0, '0);
        exp_c = '0;
        exp_c.ret = 1'b1;
        check_eq("RET ctrl", 32'(ex_bundle.ctrl), 32'(exp_c));
        check_eq("RET sp", 32'(ex_bundle.read_data_1), 32'hFFFF);
    endtask

    task automatic alu_test();
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t rd;
        word_t    d;
        ctrl_t    exp_c;
        for (int r = 1; r <= 8; r++)
            write_reg(reg_idx_t'(r), rand_bits(16));
        for (int op = 0; op < 4; op++) begin
            rs = reg_idx_t'(op + 1);
            rt = reg_idx_t'(op + 5);
            rd = reg_idx_t'(rand_bits(4));
            issue({4'(op), rd, rs, rt}, rand_bits(16), 1'b0, 1'b0, '0, '0);
            exp_c = '0;
            exp_c.reg_write = 1'b1;
            exp_c.alu_op    = alu_op_t'(op);   // ADD 0, SUB 1, AND 2, OR 3
            check_eq("ALU ctrl", 32'(ex_bundle.ctrl), 32'(exp_c));
            check_eq("ALU rs data", 32'(ex_bundle.read_data_1), 32'(model[rs]));
            check_eq("ALU rt data", 32'(ex_bundle.read_data_2), 32'(model[rt]));
            check_eq("ALU dest", 32'(ex_bundle.dest), 32'(rd));
        end
        // Writeback to r7 in the read cycle
        d = rand_bits(16);
        issue({4'd0, 4'd9, 4'd7, 4'd8}, 16'h0100, 1'b0, 1'b1, 4'd7, d);
        model[7] = d;
        check_eq("bypass rs data", 32'(ex_bundle.read_data_1), 32'(d));
        check_eq("bypass rt data", 32'(ex_bundle.read_data_2), 32'(model[8]));
    endtask

    task automatic imm_test();
        ctrl_t exp_c;
        write_reg(DS_IDX, rand_bits(16));
        issue({4'd4, 4'd2, 4'd4, 4'hA}, 16'h0120, 1'b0, 1'b0, '0, '0);   // ADDI -6
        exp_c = '0;
        exp_c.reg_write = 1'b1;
        exp_c.alu_src   = 1'b1;
        check_eq("ADDI ctrl", 32'(ex_bundle.ctrl), 32'(exp_c));
        check_eq("ADDI imm", 32'(ex_bundle.sign_ext), 32'hFFFA);
        check_eq("ADDI rs data", 32'(ex_bundle.read_data_1), 32'(model[4]));
        issue({4'd8, 4'd3, 8'h9C}, 16'h0121, 1'b0, 1'b0, '0, '0);          // LW -100
        exp_c.mem_to_reg = 1'b1;
        check_eq("LW ctrl", 32'(ex_bundle.ctrl), 32'(exp_c));
        check_eq("LW imm", 32'(ex_bundle.sign_ext), 32'hFF9C);
        check_eq("LW base", 32'(ex_bundle.read_data_1), 32'(model[DS_IDX]));
    endtask

    task automatic store_branch_test();
        ctrl_t exp_c;
        issue({4'd9, 4'd3, 8'h05}, 16'h0130, 1'b0, 1'b0, '0, '0);
        exp_c = '0;
        exp_c.reg_to_mem = 1'b1;
        exp_c.alu_src    = 1'b1;
        check_eq("SW ctrl", 32'(ex_bundle.ctrl), 32'(exp_c));
        check_eq("SW data", 32'(ex_bundle.read_data_2), 32'(model[3]));
        check_eq("SW base", 32'(ex_bundle.read_data_1), 32'(model[DS_IDX]));
        check_eq("SW imm", 32'(ex_bundle.sign_ext), 32'h0005);
        issue({4'd12, 1'b0, 3'b101, 8'h2C}, 16'h0131, 1'b0, 1'b0, '0, '0);
        exp_c = '0;
        exp_c.branch = 1'b1;
        check_eq("BR ctrl", 32'(ex_bundle.ctrl), 32'(exp_c));
        check_eq("BR cond", 32'(ex_bundle.branch_cond), 32'd5);
    endtask

    task automatic hazard_test();
        word_t add_ins;
        add_ins = {4'd0, 4'd6, 4'd2, 4'd3};   // ADD r6 = r2 + r3
        set_inflight(4'd2, 1'b1, 4'd0, 1'b0, 4'd0, 1'b0);
        issue(add_ins, 16'h0200, 1'b1, 1'b0, '0, '0);
        set_inflight(4'd0, 1'b0, 4'd3, 1'b1, 4'd0, 1'b0);
        issue(add_ins, 16'h0200, 1'b1, 1'b0, '0, '0);
        set_inflight(4'd0, 1'b0, 4'd0, 1'b0, 4'd2, 1'b1);
        issue(add_ins, 16'h0200, 1'b1, 1'b0, '0, '0);
        set_inflight(4'd2, 1'b0, 4'd3, 1'b0, 4'd2, 1'b0);   // Matches, none valid
        issue(add_ins, 16'h0200, 1'b0, 1'b0, '0, '0);
        check_eq("refetched rs data", 32'(ex_bundle.read_data_1), 32'(model[2]));
        set_inflight(4'd2, 1'b1, 4'd3, 1'b1, 4'd0, 1'b0);   // Unused fields match
        issue({4'd4, 4'd6, 4'd5, 4'd3}, 16'h0201, 1'b0, 1'b0, '0, '0);
        issue({4'd12, 4'd1, 4'd2, 4'd3}, 16'h0202, 1'b0, 1'b0, '0, '0);
        set_inflight(4'd0, 1'b0, 4'd0, 1'b0, 4'd0, 1'b0);
    endtask

    // NOP and unused opcodes become empty bundles
    task automatic nop_test();
        logic [3:0] codes [6] = '{4'd15, 4'd5, 4'd6, 4'd7, 4'd10, 4'd11};
        target_t    tgt;
        word_t      p;
        for (int i = 0; i < 6; i++) begin
            tgt = target_t'(rand_bits(12));
            p   = rand_bits(16);
            issue({codes[i], tgt}, p, 1'b0, 1'b0, '0, '0);
            check_eq("NOP ctrl", 32'(ex_bundle.ctrl), 0);
            check_eq("NOP pc", 32'(ex_bundle.pc), 32'(p));
            check_eq("NOP target", 32'(ex_bundle.call_target), 32'(tgt));
        end
    endtask

    initial begin
        clk             = 1'b0;
        rst             = 1'b1;
        instr_valid     = 1'b0;
        instr           = '0;
        pc              = '0;
        wb_en           = 1'b0;
        wb_idx          = '0;
        wb_data         = '0;
        id_ex_rd        = '0;
        id_ex_rd_valid  = 1'b0;
        ex_mem_rd       = '0;
        ex_mem_rd_valid = 1'b0;
        mem_wb_rd       = '0;
        mem_wb_rd_valid = 1'b0;
        errors          = 0;
        checks          = 0;
        lfsr            = 16'd23;
        for (int i = 0; i < 16; i++)
            model[i] = (i == 15) ? 16'hFFFF : 16'h0000;   // Reset image
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        stack_test();
        alu_test();
        imm_test();
        store_branch_test();
        hazard_test();
        nop_test();
        repeat (2) @(posedge clk);
        $display("checks %0d, errors %0d, assertion errors %0d", checks, errors,
                 decode_top_inst.decode_assert_inst.assert_errors);
        if (errors == 0 && decode_top_inst.decode_assert_inst.assert_errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

//--- sources.f
verilog/decode_pkg.sv
verilog/reg_file.sv
verilog/control_decoder.sv
verilog/operand_select.sv
verilog/hazard_detect.sv
verilog/id_ex_reg.sv
verilog/decode_top.sv
test/decode_assert.sv
test/decode_tb.sv
